//--- verilog/io_fabric_pkg.sv
`default_nettype none

package io_fabric_pkg;

   // Bus widths
   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int STRB_W     = 4;
   localparam int REG_ADDR_W = 8;
   localparam int UART_DIV_W = 16;
   localparam int PWM_REG_W  = 16;

   // Region hit when the address with mask bits cleared equals the base
   localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h4000_0000;
   localparam logic [ADDR_W-1:0] RAM_MASK  = 32'h0FFF_FFFF;
   localparam logic [ADDR_W-1:0] UART_BASE = 32'h2000_0000;
   localparam logic [ADDR_W-1:0] UART_MASK = 32'h0000_00FF;
   localparam logic [ADDR_W-1:0] PWM_BASE  = 32'h2000_0100;
   localparam logic [ADDR_W-1:0] PWM_MASK  = 32'h0000_00FF;

   // UART registers
   localparam logic [REG_ADDR_W-1:0] UART_REG_DATA   = 8'h00;
   localparam logic [REG_ADDR_W-1:0] UART_REG_STATUS = 8'h04;
   localparam logic [REG_ADDR_W-1:0] UART_REG_DIV    = 8'h08;
   localparam logic [UART_DIV_W-1:0] UART_DIV_RESET  = 16'd8;

   // PWM registers
   localparam logic [REG_ADDR_W-1:0] PWM_REG_PERIOD = 8'h00;
   localparam logic [REG_ADDR_W-1:0] PWM_REG_DUTY0  = 8'h04;
   localparam logic [REG_ADDR_W-1:0] PWM_REG_DUTY1  = 8'h08;

   typedef enum logic [1:0] {
      REGION_RAM,
      REGION_UART,
      REGION_PWM,
      REGION_NONE
   } region_e;

   // Request and response opcodes on the peripheral port
   typedef enum logic [1:0] {
      TL_GET      = 2'd0,
      TL_PUT_FULL = 2'd1,
      TL_ACK      = 2'd2,
      TL_ACK_DATA = 2'd3
   } tl_op_e;

   typedef enum logic {
      BUS_IDLE,
      BUS_WAIT_RSP
   } bus_state_e;

endpackage

`default_nettype wire

//--- verilog/io_bus_ctrl.sv
`default_nettype none

module io_bus_ctrl (
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire                                    req_valid_i,
   input  wire                                    req_write_i,
   input  wire [io_fabric_pkg::ADDR_W-1:0]        req_addr_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        req_wdata_i,
   output logic                                   req_ready_o,
   output logic                                   rsp_valid_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       rsp_data_o,
   output logic                                   iomem_valid_o,
   output logic [io_fabric_pkg::ADDR_W-1:0]       iomem_addr_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       iomem_wdata_o,
   output logic [io_fabric_pkg::STRB_W-1:0]       iomem_wstrb_o,
   input  wire                                    iomem_ready_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        iomem_rdata_i,
   output logic                                   uart_sel_o,
   output logic                                   pwm_sel_o,
   output io_fabric_pkg::tl_op_e                  periph_op_o,
   output logic [io_fabric_pkg::REG_ADDR_W-1:0]   periph_reg_addr_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       periph_wdata_o,
   input  wire                                    uart_ready_i,
   input  wire                                    uart_rsp_valid_i,
   input  wire io_fabric_pkg::tl_op_e             uart_rsp_op_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        uart_rsp_data_i,
   input  wire                                    pwm_ready_i,
   input  wire                                    pwm_rsp_valid_i,
   input  wire io_fabric_pkg::tl_op_e             pwm_rsp_op_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        pwm_rsp_data_i
);

   io_fabric_pkg::region_e            region;
   io_fabric_pkg::region_e            pend_region_q;
   io_fabric_pkg::bus_state_e         state_q;
   logic                              idle;
   logic                              ram_acc;
   logic                              periph_acc;
   logic                              pend_rsp_valid;
   io_fabric_pkg::tl_op_e             pend_rsp_op;
   logic [io_fabric_pkg::DATA_W-1:0]  pend_rsp_data;

   // Region decode by base and mask
   always_comb begin
      if ((req_addr_i & ~io_fabric_pkg::RAM_MASK) == io_fabric_pkg::RAM_BASE) begin
         region = io_fabric_pkg::REGION_RAM;
      end else if ((req_addr_i & ~io_fabric_pkg::UART_MASK) == io_fabric_pkg::UART_BASE) begin
         region = io_fabric_pkg::REGION_UART;
      end else if ((req_addr_i & ~io_fabric_pkg::PWM_MASK) == io_fabric_pkg::PWM_BASE) begin
         region = io_fabric_pkg::REGION_PWM;
      end else begin
         region = io_fabric_pkg::REGION_NONE;
      end
   end

   assign idle = (state_q == io_fabric_pkg::BUS_IDLE);

   assign iomem_valid_o = idle && req_valid_i && (region == io_fabric_pkg::REGION_RAM);
   assign iomem_addr_o  = req_addr_i;
   assign iomem_wdata_o = req_wdata_i;
   assign iomem_wstrb_o = {io_fabric_pkg::STRB_W{req_write_i}};

   assign uart_sel_o = idle && req_valid_i && (region == io_fabric_pkg::REGION_UART);
   assign pwm_sel_o  = idle && req_valid_i && (region == io_fabric_pkg::REGION_PWM);
   assign periph_op_o = req_write_i ? io_fabric_pkg::TL_PUT_FULL : io_fabric_pkg::TL_GET;
   assign periph_reg_addr_o = req_addr_i[io_fabric_pkg::REG_ADDR_W-1:0];
   assign periph_wdata_o    = req_wdata_i;

   // Unmapped region never gets ready
   assign ram_acc     = iomem_valid_o && iomem_ready_i;
   assign periph_acc  = (uart_sel_o && uart_ready_i) || (pwm_sel_o && pwm_ready_i);
   assign req_ready_o = ram_acc || periph_acc;

   // Response of the outstanding peripheral access
   always_comb begin
      if (pend_region_q == io_fabric_pkg::REGION_UART) begin
         pend_rsp_valid = uart_rsp_valid_i;
         pend_rsp_op    = uart_rsp_op_i;
         pend_rsp_data  = uart_rsp_data_i;
      end else begin
         pend_rsp_valid = pwm_rsp_valid_i;
         pend_rsp_op    = pwm_rsp_op_i;
         pend_rsp_data  = pwm_rsp_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q       <= io_fabric_pkg::BUS_IDLE;
         pend_region_q <= io_fabric_pkg::REGION_NONE;
      end else begin
         case (state_q)
            io_fabric_pkg::BUS_IDLE: begin
               if (periph_acc) begin
                  state_q       <= io_fabric_pkg::BUS_WAIT_RSP;
                  pend_region_q <= region;
               end
            end
            io_fabric_pkg::BUS_WAIT_RSP: begin
               if (pend_rsp_valid) begin
                  state_q <= io_fabric_pkg::BUS_IDLE;
               end
            end
            default: state_q <= io_fabric_pkg::BUS_IDLE;
         endcase
      end
   end

   // Only reads reach the host
   always_comb begin
      rsp_valid_o = 1'b0;
      rsp_data_o  = iomem_rdata_i;
      if (ram_acc && !req_write_i) begin
         rsp_valid_o = 1'b1;
      end else if (!idle && pend_rsp_valid && pend_rsp_op == io_fabric_pkg::TL_ACK_DATA) begin
         rsp_valid_o = 1'b1;
         rsp_data_o  = pend_rsp_data;
      end
   end

endmodule

`default_nettype wire

//--- verilog/io_uart_tx.sv
`default_nettype none

module io_uart_tx (
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire                                    sel_i,
   input  wire io_fabric_pkg::tl_op_e             op_i,
   input  wire [io_fabric_pkg::REG_ADDR_W-1:0]    reg_addr_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        wdata_i,
   output logic                                   ready_o,
   output logic                                   rsp_valid_o,
   output io_fabric_pkg::tl_op_e                  rsp_op_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       rsp_data_o,
   output logic                                   tx_o
);

   logic [io_fabric_pkg::UART_DIV_W-1:0]  div_q;
   logic [io_fabric_pkg::UART_DIV_W-1:0]  baud_cnt_q;
   logic [3:0]                            bit_cnt_q;
   logic [9:0]                            shift_q;
   logic                                  busy_q;
   logic                                  is_write;
   logic                                  accept;
   logic                                  start;
   logic                                  bit_done;
   logic [io_fabric_pkg::DATA_W-1:0]      rd_data;

   assign is_write = (op_i == io_fabric_pkg::TL_PUT_FULL);
   // Data write waits for the stop bit of the current frame
   assign ready_o  = !(busy_q && is_write && reg_addr_i == io_fabric_pkg::UART_REG_DATA);
   assign accept   = sel_i && ready_o;
   assign start    = accept && is_write && reg_addr_i == io_fabric_pkg::UART_REG_DATA;
   assign bit_done = busy_q && (baud_cnt_q == div_q - 1'b1);
   assign tx_o     = busy_q ? shift_q[0] : 1'b1;

   always_comb begin
      case (reg_addr_i)
         io_fabric_pkg::UART_REG_STATUS: rd_data = {{(io_fabric_pkg::DATA_W-1){1'b0}}, busy_q};
         io_fabric_pkg::UART_REG_DIV: begin
            rd_data = {{(io_fabric_pkg::DATA_W-io_fabric_pkg::UART_DIV_W){1'b0}}, div_q};
         end
         default: rd_data = '0;
      endcase
   end

   // Divisor and bit timing
   always_ff @(posedge clk) begin
      if (!resetn) begin
         div_q      <= io_fabric_pkg::UART_DIV_RESET;
         busy_q     <= 1'b0;
         baud_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end else begin
         if (start) begin
            busy_q     <= 1'b1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
         end else if (bit_done) begin
            baud_cnt_q <= '0;
            if (bit_cnt_q == 4'd9) begin
               busy_q <= 1'b0;
            end else begin
               bit_cnt_q <= bit_cnt_q + 4'd1;
            end
         end else if (busy_q) begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
         end
         if (accept && is_write && reg_addr_i == io_fabric_pkg::UART_REG_DIV) begin
            div_q <= wdata_i[io_fabric_pkg::UART_DIV_W-1:0];
         end
      end
   end

   // Stop, data LSB first, start
   always_ff @(posedge clk) begin
      if (start) begin
         shift_q <= {1'b1, wdata_i[7:0], 1'b0};
      end else if (bit_done) begin
         shift_q <= {1'b1, shift_q[9:1]};
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_op_o   <= is_write ? io_fabric_pkg::TL_ACK : io_fabric_pkg::TL_ACK_DATA;
         rsp_data_o <= is_write ? '0 : rd_data;
      end
   end

endmodule

`default_nettype wire

//--- verilog/io_pwm.sv
`default_nettype none

module io_pwm (
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire                                    sel_i,
   input  wire io_fabric_pkg::tl_op_e             op_i,
   input  wire [io_fabric_pkg::REG_ADDR_W-1:0]    reg_addr_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        wdata_i,
   output logic                                   ready_o,
   output logic                                   rsp_valid_o,
   output io_fabric_pkg::tl_op_e                  rsp_op_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       rsp_data_o,
   output logic                                   pwm0_o,
   output logic                                   pwm1_o
);

   localparam int PAD_W = io_fabric_pkg::DATA_W - io_fabric_pkg::PWM_REG_W;

   logic [io_fabric_pkg::PWM_REG_W-1:0]  period_q;
   logic [io_fabric_pkg::PWM_REG_W-1:0]  duty0_q;
   logic [io_fabric_pkg::PWM_REG_W-1:0]  duty1_q;
   logic [io_fabric_pkg::PWM_REG_W-1:0]  cnt_q;
   logic                                 is_write;
   logic [io_fabric_pkg::PWM_REG_W-1:0]  rd_reg;

   assign ready_o  = 1'b1;
   assign is_write = (op_i == io_fabric_pkg::TL_PUT_FULL);

   always_comb begin
      case (reg_addr_i)
         io_fabric_pkg::PWM_REG_PERIOD: rd_reg = period_q;
         io_fabric_pkg::PWM_REG_DUTY0:  rd_reg = duty0_q;
         io_fabric_pkg::PWM_REG_DUTY1:  rd_reg = duty1_q;
         default:                       rd_reg = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         period_q <= '0;
         duty0_q  <= '0;
         duty1_q  <= '0;
         cnt_q    <= '0;
      end else begin
         // Counter wraps at period - 1, a zero period parks it
         if (period_q == '0 || cnt_q >= period_q - 1'b1) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
         if (sel_i && is_write) begin
            case (reg_addr_i)
               io_fabric_pkg::PWM_REG_PERIOD: period_q <= wdata_i[io_fabric_pkg::PWM_REG_W-1:0];
               io_fabric_pkg::PWM_REG_DUTY0:  duty0_q  <= wdata_i[io_fabric_pkg::PWM_REG_W-1:0];
               io_fabric_pkg::PWM_REG_DUTY1:  duty1_q  <= wdata_i[io_fabric_pkg::PWM_REG_W-1:0];
               default: ;
            endcase
         end
      end
   end

   assign pwm0_o = (period_q != '0) && (cnt_q < duty0_q);
   assign pwm1_o = (period_q != '0) && (cnt_q < duty1_q);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= sel_i;
      end
   end

   always_ff @(posedge clk) begin
      if (sel_i) begin
         rsp_op_o   <= is_write ? io_fabric_pkg::TL_ACK : io_fabric_pkg::TL_ACK_DATA;
         rsp_data_o <= is_write ? '0 : {{PAD_W{1'b0}}, rd_reg};
      end
   end

endmodule

`default_nettype wire

//--- verilog/io_fabric_top.sv
`default_nettype none

module io_fabric_top (
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire                                    req_valid_i,
   input  wire                                    req_write_i,
   input  wire [io_fabric_pkg::ADDR_W-1:0]        req_addr_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        req_wdata_i,
   output logic                                   req_ready_o,
   output logic                                   rsp_valid_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       rsp_data_o,
   output logic                                   iomem_valid_o,
   output logic [io_fabric_pkg::ADDR_W-1:0]       iomem_addr_o,
   output logic [io_fabric_pkg::DATA_W-1:0]       iomem_wdata_o,
   output logic [io_fabric_pkg::STRB_W-1:0]       iomem_wstrb_o,
   input  wire                                    iomem_ready_i,
   input  wire [io_fabric_pkg::DATA_W-1:0]        iomem_rdata_i,
   output logic                                   uart_tx_o,
   output logic                                   pwm0_o,
   output logic                                   pwm1_o
);

   // Shared request toward the peripherals
   logic                                  uart_sel;
   logic                                  pwm_sel;
   io_fabric_pkg::tl_op_e                 periph_op;
   logic [io_fabric_pkg::REG_ADDR_W-1:0]  periph_reg_addr;
   logic [io_fabric_pkg::DATA_W-1:0]      periph_wdata;

   logic                                  uart_ready;
   logic                                  uart_rsp_valid;
   io_fabric_pkg::tl_op_e                 uart_rsp_op;
   logic [io_fabric_pkg::DATA_W-1:0]      uart_rsp_data;
   logic                                  pwm_ready;
   logic                                  pwm_rsp_valid;
   io_fabric_pkg::tl_op_e                 pwm_rsp_op;
   logic [io_fabric_pkg::DATA_W-1:0]      pwm_rsp_data;

   io_bus_ctrl io_bus_ctrl_inst (
      .clk               (clk),
      .resetn            (resetn),
      .req_valid_i       (req_valid_i),
      .req_write_i       (req_write_i),
      .req_addr_i        (req_addr_i),
      .req_wdata_i       (req_wdata_i),
      .req_ready_o       (req_ready_o),
      .rsp_valid_o       (rsp_valid_o),
      .rsp_data_o        (rsp_data_o),
      .iomem_valid_o     (iomem_valid_o),
      .iomem_addr_o      (iomem_addr_o),
      .iomem_wdata_o     (iomem_wdata_o),
      .iomem_wstrb_o     (iomem_wstrb_o),
      .iomem_ready_i     (iomem_ready_i),
      .iomem_rdata_i     (iomem_rdata_i),
      .uart_sel_o        (uart_sel),
      .pwm_sel_o         (pwm_sel),
      .periph_op_o       (periph_op),
      .periph_reg_addr_o (periph_reg_addr),
      .periph_wdata_o    (periph_wdata),
      .uart_ready_i      (uart_ready),
      .uart_rsp_valid_i  (uart_rsp_valid),
      .uart_rsp_op_i     (uart_rsp_op),
      .uart_rsp_data_i   (uart_rsp_data),
      .pwm_ready_i       (pwm_ready),
      .pwm_rsp_valid_i   (pwm_rsp_valid),
      .pwm_rsp_op_i      (pwm_rsp_op),
      .pwm_rsp_data_i    (pwm_rsp_data)
   );

   io_uart_tx io_uart_tx_inst (
      .clk         (clk),
      .resetn      (resetn),
      .sel_i       (uart_sel),
      .op_i        (periph_op),
      .reg_addr_i  (periph_reg_addr),
      .wdata_i     (periph_wdata),
      .ready_o     (uart_ready),
      .rsp_valid_o (uart_rsp_valid),
      .rsp_op_o    (uart_rsp_op),
      .rsp_data_o  (uart_rsp_data),
      .tx_o        (uart_tx_o)
   );

   io_pwm io_pwm_inst (
      .clk         (clk),
      .resetn      (resetn),
      .sel_i       (pwm_sel),
      .op_i        (periph_op),
      .reg_addr_i  (periph_reg_addr),
      .wdata_i     (periph_wdata),
      .ready_o     (pwm_ready),
      .rsp_valid_o (pwm_rsp_valid),
      .rsp_op_o    (pwm_rsp_op),
      .rsp_data_o  (pwm_rsp_data),
      .pwm0_o      (pwm0_o),
      .pwm1_o      (pwm1_o)
   );

endmodule

`default_nettype wire

//--- bench/io_fabric_asserts.sv
`default_nettype none

module io_fabric_asserts (
   input  wire                                    clk,
   input  wire                                    resetn,
   input  wire                                    req_valid_i,
   input  wire                                    req_write_i,
   input  wire [io_fabric_pkg::ADDR_W-1:0]        req_addr_i,
   input  wire                                    req_ready_i,
   input  wire                                    rsp_valid_i,
   input  wire                                    iomem_valid_i,
   input  wire                                    iomem_ready_i,
   input  wire                                    uart_tx_i,
   input  wire                                    uart_busy_i,
   input  wire io_fabric_pkg::bus_state_e         bus_state_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;
   logic        ram_hit;
   logic        ram_rd_acc;
   logic        periph_rd_acc;
   logic        periph_wr_acc;

   assign ram_hit = (req_addr_i & ~io_fabric_pkg::RAM_MASK) == io_fabric_pkg::RAM_BASE;
   assign ram_rd_acc = iomem_valid_i && iomem_ready_i && !req_write_i;
   // Peripheral accesses are the acceptances that bypass the RAM port
   assign periph_rd_acc = req_valid_i && req_ready_i && !req_write_i && !iomem_valid_i;
   assign periph_wr_acc = req_valid_i && req_ready_i && req_write_i && !iomem_valid_i;

   iomem_ram_only: assert property (@(posedge clk) disable iff (!resetn)
      iomem_valid_i |-> ram_hit)
   else begin
      fail_cnt++;
      $error("iomem_valid_o raised for non-RAM address %h", req_addr_i);
   end

   rsp_only_for_reads: assert property (@(posedge clk) disable iff (!resetn)
      rsp_valid_i |-> ram_rd_acc ||
         (bus_state_i == io_fabric_pkg::BUS_WAIT_RSP && $past(periph_rd_acc)))
   else begin
      fail_cnt++;
      $error("rsp_valid_o without a read acceptance or a pending peripheral read");
   end

   periph_rd_rsp: assert property (@(posedge clk) disable iff (!resetn)
      periph_rd_acc |=> rsp_valid_i)
   else begin
      fail_cnt++;
      $error("No response one cycle after a peripheral read");
   end

   periph_wr_quiet: assert property (@(posedge clk) disable iff (!resetn)
      periph_wr_acc |=> !rsp_valid_i)
   else begin
      fail_cnt++;
      $error("Response seen after a peripheral write");
   end

   // Idle line high and already high in the cycle before, the stop bit after a frame
   uart_idle_high: assert property (@(posedge clk) disable iff (!resetn)
      !uart_busy_i |-> uart_tx_i && $past(uart_tx_i))
   else begin
      fail_cnt++;
      $error("uart_tx_o low while the UART is idle or in the stop bit before it");
   end

   no_acc_in_wait: assert property (@(posedge clk) disable iff (!resetn)
      bus_state_i == io_fabric_pkg::BUS_WAIT_RSP |-> !req_ready_i)
   else begin
      fail_cnt++;
      $error("Request accepted while waiting for a peripheral response");
   end

endmodule

bind io_fabric_top io_fabric_asserts io_fabric_asserts_inst (
   .clk           (clk),
   .resetn        (resetn),
   .req_valid_i   (req_valid_i),
   .req_write_i   (req_write_i),
   .req_addr_i    (req_addr_i),
   .req_ready_i   (req_ready_o),
   .rsp_valid_i   (rsp_valid_o),
   .iomem_valid_i (iomem_valid_o),
   .iomem_ready_i (iomem_ready_i),
   .uart_tx_i     (uart_tx_o),
   .uart_busy_i   (io_uart_tx_inst.busy_q),
   .bus_state_i   (io_bus_ctrl_inst.state_q)
);

`default_nettype wire

//--- bench/io_fabric_tb.sv
`default_nettype none

module io_fabric_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT_CYCLES = 3000;
   localparam int RAM_WORDS      = 8;
   localparam int UART_DIV       = 8;
   localparam int PWM_PERIOD     = 10;
   localparam int PWM_DUTY0      = 3;
   localparam int PWM_DUTY1      = 7;
   localparam logic [31:0] UART_DATA_ADDR   =
      io_fabric_pkg::UART_BASE | 32'(io_fabric_pkg::UART_REG_DATA);
   localparam logic [31:0] UART_STATUS_ADDR =
      io_fabric_pkg::UART_BASE | 32'(io_fabric_pkg::UART_REG_STATUS);
   localparam logic [31:0] UART_DIV_ADDR    =
      io_fabric_pkg::UART_BASE | 32'(io_fabric_pkg::UART_REG_DIV);

   logic        clk = 1'b0;
   logic        resetn;
   logic        req_valid;
   logic        req_write;
   logic [31:0] req_addr;
   logic [31:0] req_wdata;
   wire         req_ready;
   wire         rsp_valid;
   wire  [31:0] rsp_data;
   wire         iomem_valid;
   wire  [31:0] iomem_addr;
   wire  [31:0] iomem_wdata;
   wire  [3:0]  iomem_wstrb;
   logic        iomem_ready;
   logic [31:0] iomem_rdata;
   wire         uart_tx;
   wire         pwm0;
   wire         pwm1;

   int          cycle_cnt = 0;
   int          error_cnt = 0;
   int          rx_count = 0;
   logic [7:0]  rx_bytes [0:3];
   logic [31:0] ram_mem [0:15];
   int          ram_delay;

   io_fabric_top io_fabric_top_inst (
      .clk           (clk),
      .resetn        (resetn),
      .req_valid_i   (req_valid),
      .req_write_i   (req_write),
      .req_addr_i    (req_addr),
      .req_wdata_i   (req_wdata),
      .req_ready_o   (req_ready),
      .rsp_valid_o   (rsp_valid),
      .rsp_data_o    (rsp_data),
      .iomem_valid_o (iomem_valid),
      .iomem_addr_o  (iomem_addr),
      .iomem_wdata_o (iomem_wdata),
      .iomem_wstrb_o (iomem_wstrb),
      .iomem_ready_i (iomem_ready),
      .iomem_rdata_i (iomem_rdata),
      .uart_tx_o     (uart_tx),
      .pwm0_o        (pwm0),
      .pwm1_o        (pwm1)
   );

   always #20 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         error_cnt++;
         $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic finish_run(input logic timed_out);
      int unsigned assert_errors;
      assert_errors = io_fabric_top_inst.io_fabric_asserts_inst.fail_cnt;
      $display("Run ended after %0d cycles: %0d value errors, %0d assertion failures",
               cycle_cnt, error_cnt, assert_errors);
      if (timed_out || error_cnt != 0 || assert_errors != 0) begin
         $display("Something failed");
      end else begin
         $display("Everything OK");
      end
      $finish;
   endtask

   // One host access; RAM reads answer in the acceptance cycle, peripherals one later
   task automatic bus_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int acc_cycle);
      logic        is_ram;
      logic [31:0] data_now;
      is_ram = (addr & ~io_fabric_pkg::RAM_MASK) == io_fabric_pkg::RAM_BASE;
      @(posedge clk);
      req_valid <= 1'b1;
      req_write <= write;
      req_addr  <= addr;
      req_wdata <= wdata;
      @(negedge clk);
      while (!req_ready) begin
         @(negedge clk);
      end
      acc_cycle = cycle_cnt;
      data_now  = rsp_data;
      if (is_ram) begin
         check_value("iomem_addr_o", addr, iomem_addr);
         check_value("iomem_wstrb_o", write ? 32'hF : 32'h0, 32'(iomem_wstrb));
         if (write) begin
            check_value("iomem_wdata_o", wdata, iomem_wdata);
         end
         check_value("rsp_valid_o", 32'(!write), 32'(rsp_valid));
      end else begin
         check_value("rsp_valid_o", 32'h0, 32'(rsp_valid));
      end
      @(posedge clk);
      req_valid <= 1'b0;
      if (!is_ram) begin
         @(negedge clk);
         check_value("rsp_valid_o", 32'(!write), 32'(rsp_valid));
         data_now = rsp_data;
      end
      rdata = data_now;
   endtask

   // Two peripheral reads; the second is already on the bus during the first's response
   task automatic read_pair(input logic [31:0] addr_a, input logic [31:0] addr_b,
                            output logic [31:0] data_a, output logic [31:0] data_b,
                            output int gap);
      int acc_a;
      @(posedge clk);
      req_valid <= 1'b1;
      req_write <= 1'b0;
      req_addr  <= addr_a;
      @(negedge clk);
      while (!req_ready) begin
         @(negedge clk);
      end
      acc_a = cycle_cnt;
      @(posedge clk);
      req_addr <= addr_b;
      @(negedge clk);
      check_value("rsp_valid_o", 32'h1, 32'(rsp_valid));
      data_a = rsp_data;
      while (!req_ready) begin
         @(negedge clk);
      end
      gap = cycle_cnt - acc_a;
      @(posedge clk);
      req_valid <= 1'b0;
      @(negedge clk);
      check_value("rsp_valid_o", 32'h1, 32'(rsp_valid));
      data_b = rsp_data;
   endtask

   // RAM model with 0 to 3 cycles of ready delay
   initial begin
      for (int i = 0; i < 16; i++) begin
         ram_mem[i] = 32'h5A00_0000 | (i * 32'h0001_0203);
      end
   end

   always @(posedge clk) begin
      if (!resetn) begin
         iomem_ready <= 1'b0;
         ram_delay = $urandom_range(3, 0);
      end else if (iomem_ready) begin
         iomem_ready <= 1'b0;
      end else if (iomem_valid) begin
         if (ram_delay == 0) begin
            iomem_ready <= 1'b1;
            iomem_rdata <= ram_mem[iomem_addr[5:2]];
            if (iomem_wstrb == 4'hF) begin
               ram_mem[iomem_addr[5:2]] <= iomem_wdata;
            end
            ram_delay = $urandom_range(3, 0);
         end else begin
            ram_delay--;
         end
      end
   end

   // UART receiver, samples mid-bit at the known divisor
   initial begin : uart_monitor
      logic [7:0] rx_byte;
      @(posedge resetn);
      forever begin
         @(negedge uart_tx);
         repeat (UART_DIV / 2) @(posedge clk);
         @(negedge clk);
         check_value("uart_tx_o start bit", 32'h0, 32'(uart_tx));
         for (int b = 0; b < 8; b++) begin
            repeat (UART_DIV) @(negedge clk);
            rx_byte[b] = uart_tx;
         end
         repeat (UART_DIV) @(negedge clk);
         check_value("uart_tx_o stop bit", 32'h1, 32'(uart_tx));
         rx_bytes[rx_count] = rx_byte;
         rx_count++;
      end
   end

   initial begin : watchdog
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      finish_run(1'b1);
   end

   initial begin : stimulus
      logic [31:0] rdata;
      logic [31:0] rdata_b;
      logic [31:0] ram_exp [0:RAM_WORDS-1];
      int          acc_first;
      int          acc_second;
      int          acc_gap;
      int          high0;
      int          high1;
      void'($urandom(32'h3055));
      resetn      = 1'b0;
      req_valid   = 1'b0;
      req_write   = 1'b0;
      req_addr    = '0;
      req_wdata   = '0;
      iomem_ready = 1'b0;
      iomem_rdata = '0;
      repeat (8) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check_value("iomem_valid_o", 32'h0, 32'(iomem_valid));
      check_value("req_ready_o", 32'h0, 32'(req_ready));
      check_value("rsp_valid_o", 32'h0, 32'(rsp_valid));
      check_value("uart_tx_o", 32'h1, 32'(uart_tx));
      check_value("pwm0_o", 32'h0, 32'(pwm0));
      check_value("pwm1_o", 32'h0, 32'(pwm1));

      // RAM write and read back
      for (int i = 0; i < RAM_WORDS; i++) begin
         ram_exp[i] = $urandom();
         bus_access(1'b1, io_fabric_pkg::RAM_BASE + 32'(i * 4), ram_exp[i], rdata, acc_first);
      end
      for (int i = 0; i < RAM_WORDS; i++) begin
         bus_access(1'b0, io_fabric_pkg::RAM_BASE + 32'(i * 4), '0, rdata, acc_first);
         check_value("rsp_data_o", ram_exp[i], rdata);
      end

      // PWM
      bus_access(1'b1, io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_PERIOD),
                 32'(PWM_PERIOD), rdata, acc_first);
      bus_access(1'b1, io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_DUTY0),
                 32'(PWM_DUTY0), rdata, acc_first);
      bus_access(1'b1, io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_DUTY1),
                 32'(PWM_DUTY1), rdata, acc_first);
      bus_access(1'b0, io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_PERIOD),
                 '0, rdata, acc_first);
      check_value("pwm period", 32'(PWM_PERIOD), rdata);
      read_pair(io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_DUTY0),
                io_fabric_pkg::PWM_BASE | 32'(io_fabric_pkg::PWM_REG_DUTY1),
                rdata, rdata_b, acc_gap);
      check_value("pwm duty0", 32'(PWM_DUTY0), rdata);
      check_value("pwm duty1", 32'(PWM_DUTY1), rdata_b);
      check_value("req_ready_o acceptance gap", 32'h2, 32'(acc_gap));
      high0 = 0;
      high1 = 0;
      repeat (PWM_PERIOD) begin
         @(negedge clk);
         high0 += int'(pwm0);
         high1 += int'(pwm1);
      end
      check_value("pwm0_o high cycles", 32'(PWM_DUTY0), 32'(high0));
      check_value("pwm1_o high cycles", 32'(PWM_DUTY1), 32'(high1));

      // UART single frame with a status read while busy
      bus_access(1'b1, UART_DIV_ADDR, 32'(UART_DIV), rdata, acc_first);
      bus_access(1'b0, UART_DIV_ADDR, '0, rdata, acc_first);
      check_value("uart divisor", 32'(UART_DIV), rdata);
      bus_access(1'b1, UART_DATA_ADDR, 32'h0000_00A7, rdata, acc_first);
      bus_access(1'b0, UART_STATUS_ADDR, '0, rdata, acc_first);
      check_value("uart status", 32'h1, rdata);
      wait (rx_count >= 1);
      check_value("uart byte 0", 32'hA7, 32'(rx_bytes[0]));

      // Second data write stalls until the stop bit ends
      bus_access(1'b1, UART_DATA_ADDR, 32'h0000_003C, rdata, acc_first);
      bus_access(1'b1, UART_DATA_ADDR, 32'h0000_00C5, rdata, acc_second);
      if (acc_second - acc_first < 10 * UART_DIV) begin
         error_cnt++;
         $display("Second UART write accepted %0d cycles after the first, before the stop bit",
                  acc_second - acc_first);
      end
      wait (rx_count >= 3);
      check_value("uart byte 1", 32'h3C, 32'(rx_bytes[1]));
      check_value("uart byte 2", 32'hC5, 32'(rx_bytes[2]));
      repeat (4) @(posedge clk);
      finish_run(1'b0);
   end

endmodule

`default_nettype wire

//--- io_fabric.f
verilog/io_fabric_pkg.sv
verilog/io_bus_ctrl.sv
verilog/io_uart_tx.sv
verilog/io_pwm.sv
verilog/io_fabric_top.sv
bench/io_fabric_asserts.sv
bench/io_fabric_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := io_fabric_tb
FILELIST  := io_fabric.f
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
FAIL_MSG  := Something failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
